// File: common/rob_pkg.sv
package rob_pkg;

	// ********************************************************************
	// Sizes
	// ********************************************************************

	localparam int tag_width  = 3;     // Bits in a buffer index
	localparam int rob_depth  = 8;     // Entries in the buffer (7 usable)
	localparam int data_width = 16;    // Result value and register width
	localparam int reg_count  = 8;     // Architectural registers r0..r7
	localparam int cnt_width  = 8;     // Mispredict counter width

	// LC-3b opcodes in their native 4-bit encoding
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ld   = 4'b0010,
		op_st   = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef logic [2:0] lc3b_reg;              // Architectural register index
	typedef logic [tag_width-1:0] rob_tag;     // Buffer entry index

	// One buffer slot, 25 bits wide
	typedef struct packed {
		lc3b_opcode            inst;       // Opcode of the instruction
		lc3b_reg               dest;       // Destination register
		logic                  predict;    // Branch prediction, only meaningful for op_br
		logic                  valid;      // Value has been produced
		logic [data_width-1:0] value;      // Result, bit 0 is the branch outcome
	} rob_entry;

	// Allocation request into the tail
	typedef struct packed {
		logic       strobe;
		lc3b_opcode inst;
		lc3b_reg    dest;
		logic       predict;
	} issue_req;

	// Result delivery by tag
	typedef struct packed {
		logic                  strobe;
		rob_tag                tag;
		logic [data_width-1:0] value;
	} complete_req;

	// ********************************************************************
	// APB and register map
	// ********************************************************************

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp;

	localparam logic [7:0] addr_issue    = 8'h00;  // W: inst[3:0] dest[6:4] predict[8]
	localparam logic [7:0] addr_complete = 8'h04;  // W: tag[2:0] value[31:16]
	localparam logic [7:0] addr_status   = 8'h08;  // R: empty full tail count
	localparam logic [7:0] addr_reg_base = 8'h10;  // R: r0 at 0x10, r7 at 0x2C
	localparam logic [7:0] reg_addr_mask = 8'he3;  // Strips the register index bits

endpackage

// File: design/apb_rob_port.sv
`timescale 1ns/1ns

module apb_rob_port import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  apb_req                apb_in,
	input  logic                  empty,        // Buffer status for the status register
	input  logic                  full,
	input  rob_tag                tail_tag,
	input  logic [cnt_width-1:0]  mispredicts,
	input  logic [data_width-1:0] reg_data,     // Register file read port
	output apb_rsp                apb_out,
	output issue_req              issue,
	output complete_req           complete,
	output lc3b_reg               reg_sel       // Register file read address
);

	logic        setup;          // First cycle of a transfer
	logic        access;         // Second cycle, where the transfer takes effect
	logic        hit_issue;
	logic        hit_complete;
	logic        hit_status;
	logic        hit_reg;
	logic [7:0]  reg_off;        // Byte offset into the register window
	logic        err_q;          // Issue rejected, valid through the access phase
	logic [31:0] status_word;
	logic [31:0] rd_data;

	// ********************************************************************
	// Phase and address decode
	// ********************************************************************

	assign setup  = apb_in.psel & ~apb_in.penable;
	assign access = apb_in.psel & apb_in.penable;

	assign hit_issue    = apb_in.paddr == addr_issue;
	assign hit_complete = apb_in.paddr == addr_complete;
	assign hit_status   = apb_in.paddr == addr_status;

	assign reg_off = apb_in.paddr - addr_reg_base;
	assign hit_reg = (reg_off & reg_addr_mask) == 8'h00;  // 0x10..0x2C

	assign reg_sel = reg_off[4:2];    // Word index inside the register window

	// The full flag is sampled at the end of the setup phase
	// Only this port can fill the buffer, so a buffer that is not full
	// then cannot become full before the access edge
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			err_q <= 1'b0;
		else
			err_q <= setup & apb_in.pwrite & hit_issue & full;   // Cleared again after access
	end

	// ********************************************************************
	// Producer strobes
	// ********************************************************************

	always_comb
	begin
		issue.strobe  = access & apb_in.pwrite & hit_issue & ~err_q;
		issue.inst    = lc3b_opcode'(apb_in.pwdata[3:0]);
		issue.dest    = apb_in.pwdata[6:4];
		issue.predict = apb_in.pwdata[8];
	end

	always_comb
	begin
		complete.strobe = access & apb_in.pwrite & hit_complete;  // Range check is in the buffer
		complete.tag    = apb_in.pwdata[tag_width-1:0];
		complete.value  = apb_in.pwdata[31:16];
	end

	// ********************************************************************
	// Read data
	// ********************************************************************

	// Status layout: empty[0] full[1] tail[6:4] mispredicts[15:8]
	assign status_word = {16'h0000, mispredicts, 1'b0, tail_tag, 2'b00, full, empty};

	always_comb
	begin
		rd_data = 32'h0;                                  // Write-only addresses read as zero
		if (hit_status)
			rd_data = status_word;
		else if (hit_reg)
			rd_data = {{(32-data_width){1'b0}}, reg_data};
	end

	always_comb
	begin
		apb_out.prdata  = (access & ~apb_in.pwrite) ? rd_data : 32'h0;
		apb_out.pready  = 1'b1;                          // Zero wait states
		apb_out.pslverr = access & err_q;                // Only a rejected issue errors
	end

endmodule

// File: reorder_buffer/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer import rob_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  issue_req    issue,       // Allocate at the tail
	input  complete_req complete,    // Write a result by tag
	input  logic        retire,      // Pop the head
	input  logic        flush,       // Drop everything
	output rob_entry    head,        // Oldest entry, for the commit unit
	output logic        empty,
	output logic        full,
	output rob_tag      tail_tag     // Tag the next issue will get
);

	rob_entry             entries [rob_depth];  // Payload storage
	logic [rob_depth-1:0] valid_q;              // Per-slot valid bits, kept apart from payload
	rob_tag               head_q;               // Oldest occupied slot
	rob_tag               tail_q;               // Next free slot
	rob_tag               tail_next;
	rob_tag               head_next;
	rob_tag               cmp_off;              // Distance of the completing tag from head
	rob_tag               used_cnt;             // Number of occupied slots
	logic                 cmp_in_range;
	logic                 do_issue;
	logic                 do_complete;
	logic                 do_retire;

	// ********************************************************************
	// Pointer arithmetic and flags
	// ********************************************************************

	assign tail_next = tail_q + rob_tag'(1);   // Wraps with the tag width
	assign head_next = head_q + rob_tag'(1);

	// One slot is always left free so that head == tail means empty only
	assign empty    = head_q == tail_q;
	assign full     = tail_next == head_q;
	assign tail_tag = tail_q;

	// A tag is occupied when its offset from head is below the fill level
	// Modular subtraction takes care of the wrapped case
	assign cmp_off      = complete.tag - head_q;
	assign used_cnt     = tail_q - head_q;
	assign cmp_in_range = cmp_off < used_cnt;

	assign do_issue    = issue.strobe & ~full & ~flush;      // Flush wins over issue
	assign do_complete = complete.strobe & cmp_in_range;
	assign do_retire   = retire & ~empty;

	// Head view combines the stored payload with the live valid bit
	always_comb
	begin
		head       = entries[head_q];
		head.valid = valid_q[head_q];
	end

	// ********************************************************************
	// Payload storage
	// ********************************************************************

	always_ff @(posedge clk)
	begin
		if (do_issue)
		begin
			entries[tail_q] <= '{
				inst:    issue.inst,
				dest:    issue.dest,
				predict: issue.predict,
				valid:   1'b0,
				value:   '0
			};
		end
		if (do_complete)
			entries[complete.tag].value <= complete.value;  // Result lands out of order
	end

	// ********************************************************************
	// Pointers and valid bits
	// ********************************************************************

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head_q  <= '0;
			tail_q  <= '0;
			valid_q <= '0;
		end
		else if (flush)
		begin
			// Mispredict throws away all younger work
			// The head does not advance, both pointers go back to slot 0
			head_q  <= '0;
			tail_q  <= '0;
			valid_q <= '0;
		end
		else
		begin
			if (do_issue)
			begin
				valid_q[tail_q] <= 1'b0;      // New entry waits for its result
				tail_q          <= tail_next;
			end

			if (do_complete)
				valid_q[complete.tag] <= 1'b1;

			// Retirement comes last so a stale completion to the head cannot
			// leave a valid bit behind in a slot that has just been freed
			if (do_retire)
			begin
				valid_q[head_q] <= 1'b0;
				head_q          <= head_next;
			end
		end
	end

endmodule

// File: design/rob_commit.sv
`timescale 1ns/1ns

module rob_commit import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  rob_entry              head,          // Oldest buffer entry
	input  logic                  empty,
	output logic                  retire,        // Pop the head this cycle
	output logic                  flush,         // Branch went the other way
	output logic                  reg_we,
	output lc3b_reg               reg_waddr,
	output logic [data_width-1:0] reg_wdata,
	output logic [cnt_width-1:0]  mispredicts    // Running count, wraps
);

	logic                 writes_reg;    // Opcode produces a register result
	logic                 is_branch;
	logic                 outcome;       // Actual direction of a branch
	logic                 mispredict;
	logic [cnt_width-1:0] count_q;

	// ********************************************************************
	// Retire decision
	// ********************************************************************

	// In-order retirement, one entry per clock as soon as the head has its value
	assign retire = ~empty & head.valid;

	always_comb
	begin
		case (head.inst)
			op_br,
			op_st,
			op_str,
			op_sti,
			op_jmp:  writes_reg = 1'b0;    // Control flow and stores leave the registers alone
			default: writes_reg = 1'b1;
		endcase
	end

	// ********************************************************************
	// Branch check
	// ********************************************************************

	assign is_branch  = head.inst == op_br;
	assign outcome    = head.value[0];     // Execution reports the direction in bit 0
	assign mispredict = retire & is_branch & (head.predict != outcome);

	assign flush = mispredict;             // The branch itself still retires

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			count_q <= '0;
		else if (mispredict)
			count_q <= count_q + cnt_width'(1);  // Rolls over at 256
	end

	assign mispredicts = count_q;

	// ********************************************************************
	// Register write port
	// ********************************************************************

	// Write lands on the same edge that pops the head
	assign reg_we    = retire & writes_reg;
	assign reg_waddr = head.dest;
	assign reg_wdata = head.value;

endmodule

// File: design/arch_regfile.sv
`timescale 1ns/1ns

module arch_regfile import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  we,        // Commit-side write enable
	input  lc3b_reg               waddr,
	input  logic [data_width-1:0] wdata,
	input  lc3b_reg               raddr,     // Host-side read address
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] regs [reg_count];   // r0..r7

	// Architectural state, only retired results ever get here
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[waddr] <= wdata;
		end
	end

	// Plain read with no bypass, so a same-cycle write shows up next cycle
	assign rdata = regs[raddr];

endmodule

// File: design/rob_subsystem_top.sv
`timescale 1ns/1ns

module rob_subsystem_top import rob_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  apb_req apb_in,     // Host bus
	output apb_rsp apb_out
);

	// ********************************************************************
	// Interconnect
	// ********************************************************************

	issue_req              issue;          // Port to buffer
	complete_req           complete;
	rob_entry              head;           // Buffer to commit
	logic                  empty;
	logic                  full;
	rob_tag                tail_tag;
	logic                  retire;         // Commit back to buffer
	logic                  flush;
	logic                  reg_we;         // Commit to register file
	lc3b_reg               reg_waddr;
	logic [data_width-1:0] reg_wdata;
	logic [cnt_width-1:0]  mispredicts;
	lc3b_reg               reg_sel;        // Port to register file read side
	logic [data_width-1:0] reg_data;

	// Host access and producer
	apb_rob_port u_port (
		.clk         (clk),
		.rst_n       (rst_n),
		.apb_in      (apb_in),
		.empty       (empty),
		.full        (full),
		.tail_tag    (tail_tag),
		.mispredicts (mispredicts),
		.reg_data    (reg_data),
		.apb_out     (apb_out),
		.issue       (issue),
		.complete    (complete),
		.reg_sel     (reg_sel)
	);

	reorder_buffer u_rob (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.complete (complete),
		.retire   (retire),
		.flush    (flush),
		.head     (head),
		.empty    (empty),
		.full     (full),
		.tail_tag (tail_tag)
	);

	// In-order retirement and branch check
	rob_commit u_commit (
		.clk         (clk),
		.rst_n       (rst_n),
		.head        (head),
		.empty       (empty),
		.retire      (retire),
		.flush       (flush),
		.reg_we      (reg_we),
		.reg_waddr   (reg_waddr),
		.reg_wdata   (reg_wdata),
		.mispredicts (mispredicts)
	);

	arch_regfile u_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (reg_we),
		.waddr (reg_waddr),
		.wdata (reg_wdata),
		.raddr (reg_sel),
		.rdata (reg_data)
	);

endmodule

// File: testbench/rob_model.svh
`ifndef rob_model_svh
`define rob_model_svh

// **********************************************************************
// Reference model of the buffer, the commit rules and the registers
// **********************************************************************

rob_entry              m_list [rob_depth];    // Entries indexed by tag
rob_tag                m_head;                // Oldest occupied slot
rob_tag                m_tail;                // Next slot to allocate
logic [data_width-1:0] m_regs [reg_count];    // Expected architectural registers
logic [cnt_width-1:0]  m_mis;                 // Expected mispredict count

// Stores, branches and JMP leave the register file alone
function automatic logic writes_reg(lc3b_opcode op);
	case (op)
		op_br, op_st, op_str, op_sti, op_jmp: return 1'b0;
		default:                              return 1'b1;
	endcase
endfunction

function automatic void reset_model();
	m_head = '0;
	m_tail = '0;
	m_mis  = '0;
	for (int i = 0; i < rob_depth; i++)
		m_list[i] = '0;
	for (int i = 0; i < reg_count; i++)
		m_regs[i] = '0;
endfunction

function automatic int used_slots();
	return int'(rob_tag'(m_tail - m_head));   // Occupancy, at most 7
endfunction

// Returns 1 when the entry was accepted, 0 when the buffer was full
function automatic logic issue_entry(lc3b_opcode op, lc3b_reg d, logic p);
	if (used_slots() == rob_depth - 1)
		return 1'b0;
	m_list[m_tail].inst    = op;
	m_list[m_tail].dest    = d;
	m_list[m_tail].predict = p;
	m_list[m_tail].valid   = 1'b0;            // Waits for its result
	m_list[m_tail].value   = '0;
	m_tail = m_tail + 1'b1;
	return 1'b1;
endfunction

// Applies a completion, then retires in order until the head is not valid
// Returns how many entries retired, so the caller knows how long to wait
function automatic int complete_entry(rob_tag t, logic [data_width-1:0] v);
	int     n;
	rob_tag off;
	n   = 0;
	off = t - m_head;
	if (int'(off) >= used_slots())
		return 0;                              // Outside head..tail, ignored
	m_list[t].value = v;
	m_list[t].valid = 1'b1;
	while (m_head != m_tail && m_list[m_head].valid)
	begin
		n++;
		if (writes_reg(m_list[m_head].inst))
			m_regs[m_list[m_head].dest] = m_list[m_head].value;
		if (m_list[m_head].inst == op_br && m_list[m_head].predict != m_list[m_head].value[0])
		begin
			m_mis  = m_mis + 1'b1;               // Wraps at 256
			m_head = '0;                         // Flush empties the buffer
			m_tail = '0;
			for (int i = 0; i < rob_depth; i++)
				m_list[i].valid = 1'b0;
		end
		else
		begin
			m_list[m_head].valid = 1'b0;
			m_head = m_head + 1'b1;
		end
	end
	return n;
endfunction

`endif

// File: testbench/rob_tb.sv
`timescale 1ns/1ns

module rob_tb import rob_pkg::*;
;

	// Transfers in all six tests, counted generously
	localparam int xfers_planned = 142;
	localparam int cycle_limit   = 40 * xfers_planned + 100;

	logic   clk = 1'b0;
	logic   rst_n;
	apb_req apb_in;
	apb_rsp apb_out;
	int     errors = 0;
	int     checks = 0;
	int     tests  = 0;

	`include "rob_model.svh"

	rob_subsystem_top DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_in  (apb_in),
		.apb_out (apb_out)
	);

	always
		#50 clk = ~clk;       // 100 ns period

	// **********************************************************************
	// APB driver
	// **********************************************************************

	task automatic bus_cycle(input logic wr, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic slverr);
		logic ready;
		@(posedge clk);
		apb_in.psel    <= 1'b1;   // Setup phase
		apb_in.penable <= 1'b0;
		apb_in.pwrite  <= wr;
		apb_in.paddr   <= addr;
		apb_in.pwdata  <= data;
		@(posedge clk);
		apb_in.penable <= 1'b1;   // Access phase
		@(negedge clk);
		rdata  = apb_out.prdata;  // Settled halfway through the access phase
		slverr = apb_out.pslverr;
		ready  = apb_out.pready;
		checks++;
		if (ready !== 1'b1)
		begin
			errors++;
			$display("** Error apb access at %h: expected pready 1, actual %b", addr, ready);
		end
		@(posedge clk);
		apb_in <= '0;             // The transfer took effect at this edge
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		bus_cycle(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		bus_cycle(1'b0, addr, 32'h0, data, err);
	endtask

	// **********************************************************************
	// Compare tasks
	// **********************************************************************

	task automatic check_reg(input string name, input logic [data_width-1:0] exp,
		input logic [data_width-1:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic exp_empty, input logic exp_full,
		input rob_tag exp_tail, input logic [cnt_width-1:0] exp_mis, input logic act_empty,
		input logic act_full, input rob_tag act_tail, input logic [cnt_width-1:0] act_mis);
		checks++;
		if ({act_empty, act_full, act_tail, act_mis} !== {exp_empty, exp_full, exp_tail, exp_mis})
		begin
			errors++;
			$display("** Error %s: expected empty=%b full=%b tail=%0d mispredicts=%0d, %s",
				name, exp_empty, exp_full, exp_tail, exp_mis,
				$sformatf("actual empty=%b full=%b tail=%0d mispredicts=%0d",
					act_empty, act_full, act_tail, act_mis));
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("** Error %s: expected pslverr %b, actual %b", name, exp, act);
		end
	endtask

	// **********************************************************************
	// Operations that keep the model in step with the DUT
	// **********************************************************************

	task automatic issue_op(input lc3b_opcode op, input lc3b_reg d, input logic p,
		input string name);
		logic e;
		logic exp_err;
		exp_err = ~issue_entry(op, d, p);                  // Full buffer rejects
		apb_write(addr_issue, {23'h0, p, 1'b0, d, op}, e);
		check_err(name, exp_err, e);
	endtask

	task automatic complete_op(input rob_tag t, input logic [data_width-1:0] v);
		int   n;
		logic e;
		n = complete_entry(t, v);
		apb_write(addr_complete, {v, 13'h0, t}, e);
		check_err("complete", 1'b0, e);                   // Completions never error
		repeat (n + 2) @(posedge clk);                    // Retirement chain, then settle
	endtask

	task automatic verify_regs(input string name);
		logic [31:0] d;
		for (int r = 0; r < reg_count; r++)
		begin
			apb_read(addr_reg_base + 8'(4 * r), d);
			check_reg($sformatf("%s r%0d", name, r), m_regs[r], d[data_width-1:0]);
		end
	endtask

	task automatic verify_status(input string name);
		logic [31:0] d;
		apb_read(addr_status, d);
		check_status(name, m_head == m_tail, used_slots() == rob_depth - 1, m_tail, m_mis,
			d[0], d[1], d[6:4], d[15:8]);
	endtask

	task automatic end_test(input string name, input int start);
		tests++;
		$display("%-12s %s", name, (errors == start) ? "passed" : "FAILED");
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		lc3b_opcode op;
		rob_tag     tags[$];
		rob_tag     base;
		logic       p;
		int         k;
		int         start;
		k = $urandom(32'hf576181e);      // Seeds the generator once
		rst_n  <= 1'b0;
		apb_in <= '0;
		reset_model();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		start = errors;                  // Reset state
		verify_status("reset");
		verify_regs("reset");
		end_test("reset", start);

		start = errors;                  // Five writers completed out of order
		for (int i = 0; i < 5; i++)
		begin
			do
				op = lc3b_opcode'(4'($urandom));
			while (!writes_reg(op));
			tags.push_back(m_tail);
			issue_op(op, lc3b_reg'($urandom % 4), 1'($urandom), "ooo issue");  // Dests overlap
		end
		while (tags.size() > 0)
		begin
			k = $urandom % tags.size();
			complete_op(tags[k], 16'($urandom));
			tags.delete(k);
		end
		verify_regs("ooo");
		verify_status("ooo");
		end_test("ooo", start);

		start = errors;                  // Fill to 7, then one more
		for (int i = 0; i < 7; i++)
			issue_op(op_st, 3'd0, 1'b0, "fill issue");
		verify_status("fill");
		issue_op(op_st, 3'd0, 1'b0, "overflow");
		verify_status("overflow");
		while (m_head != m_tail)
			complete_op(m_head, 16'($urandom));
		end_test("full", start);

		start = errors;                  // Branch predicted right
		p    = 1'($urandom);
		base = m_tail;
		issue_op(op_br, 3'd0, p, "hit issue");
		issue_op(op_add, 3'd5, 1'b0, "hit issue");
		issue_op(op_not, 3'd6, 1'b0, "hit issue");
		complete_op(base + 3'd2, 16'($urandom));
		complete_op(base + 3'd1, 16'($urandom));
		complete_op(base, {15'($urandom), p});
		verify_regs("br_hit");
		verify_status("br_hit");
		end_test("br_hit", start);

		start = errors;                  // Branch predicted wrong, younger work flushed
		p    = 1'($urandom);
		base = m_tail;
		issue_op(op_br, 3'd0, p, "miss issue");
		issue_op(op_add, 3'd5, 1'b0, "miss issue");
		issue_op(op_not, 3'd6, 1'b0, "miss issue");
		complete_op(base + 3'd2, 16'($urandom));
		complete_op(base + 3'd1, 16'($urandom));
		complete_op(base, {15'($urandom), ~p});
		verify_regs("br_miss");
		verify_status("br_miss");
		complete_op(base + 3'd1, 16'($urandom));   // Stale tags after the flush
		complete_op(base + 3'd2, 16'($urandom));
		verify_regs("stale");
		verify_status("stale");
		end_test("br_miss", start);

		start = errors;                  // Random mix of issues and completions
		for (int i = 0; i < 40; i++)
		begin
			if (used_slots() == 0 || (used_slots() < rob_depth - 1 && 1'($urandom)))
				issue_op(lc3b_opcode'(4'($urandom)), 3'($urandom), 1'($urandom), "rand issue");
			else
				complete_op(m_head + rob_tag'($urandom % used_slots()), 16'($urandom));
		end
		while (m_head != m_tail)
			complete_op(m_head, 16'($urandom));
		verify_regs("random");
		verify_status("random");
		end_test("random", start);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog sized from the planned transfer count
	initial
	begin
		repeat (cycle_limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+testbench
common/rob_pkg.sv
design/apb_rob_port.sv
reorder_buffer/reorder_buffer.sv
design/rob_commit.sv
design/arch_regfile.sv
design/rob_subsystem_top.sv
testbench/rob_tb.sv
